// ==== source/emif_defines.svh ====
// Widths of the DDR4 bank port; only the low EMIF_STORE_AW word address bits reach storage
`ifndef EMIF_DEFINES_SVH
`define EMIF_DEFINES_SVH

// ==================================================
// Port widths of one bank
// ==================================================

// Bits per memory word, one full DDR4 controller beat
`define EMIF_DATA_WIDTH 512

// Word address bits on the port
// The byte-address bits below bit 0 are not carried
`define EMIF_ADDR_WIDTH 26

// Burst count bits, so a burst holds 1 to 127 words
`define EMIF_BURST_WIDTH 7

// ==================================================
// Storage depth
// ==================================================

// Log2 of the words held per bank
// Address bits above this are ignored and alias onto the same words
`define EMIF_STORE_AW 8

// One enable per data byte
`define EMIF_BE_WIDTH (`EMIF_DATA_WIDTH / 8)

`endif

// ==== source/avmm_types_pkg.sv ====
// Bus types of one bank port; store_idx_t covers only the low EMIF_STORE_AW address bits
`default_nettype none

`include "emif_defines.svh"

package avmm_types_pkg;

  // ==================================================
  // Avalon-MM slave port fields
  // ==================================================

  // One memory word as carried on readdata and writedata
  typedef logic [`EMIF_DATA_WIDTH-1:0] data_t;

  // Word address as presented by the master
  typedef logic [`EMIF_ADDR_WIDTH-1:0] addr_t;

  // Byte enables, bit i covers data bits 8*i+7 down to 8*i
  typedef logic [`EMIF_BE_WIDTH-1:0] be_t;

  // Burst length in words, zero is not a legal length
  typedef logic [`EMIF_BURST_WIDTH-1:0] burst_t;

  // ==================================================
  // Storage side
  // ==================================================

  // Index into the word array of one bank
  typedef logic [`EMIF_STORE_AW-1:0] store_idx_t;

endpackage

`default_nettype wire

// ==== source/bank_ctrl_pkg.sv ====
// State encoding of the per-bank burst sequencer; one burst is in flight at a time
`default_nettype none

package bank_ctrl_pkg;

  // Sequencer states of one bank
  // idle accepts a new command
  // rd_burst issues one read word per cycle and holds waitrequest
  // wr_burst takes one write word on every cycle with write high
  typedef enum logic [1:0] {
    idle     = 2'd0,
    rd_burst = 2'd1,
    wr_burst = 2'd2
  } burst_state_t;

endpackage

`default_nettype wire

// ==== source/burst_ctrl.sv ====
// Sequencer for one bank; burstcount must be 1 to 127 and byteenable is latched once per burst
`default_nettype none
`timescale 1ns/1ns

`include "emif_defines.svh"

module burst_ctrl (
  input  logic                       DDR4_USERCLK,
  input  logic                       rst,
  input  logic                       read,
  input  logic                       write,
  input  avmm_types_pkg::addr_t      address,
  input  avmm_types_pkg::burst_t     burstcount,
  input  avmm_types_pkg::be_t        byteenable,
  output logic                       waitrequest,
  output logic                       rd_en,
  output logic                       wr_en,
  output avmm_types_pkg::store_idx_t idx,
  output avmm_types_pkg::be_t        lane_be
);

  bank_ctrl_pkg::burst_state_t state;

  // Words still to move in the current burst
  avmm_types_pkg::burst_t remaining;

  // Running word index and the enables latched at acceptance
  avmm_types_pkg::store_idx_t addr_q;
  avmm_types_pkg::be_t        be_q;

  avmm_types_pkg::store_idx_t address_idx;
  logic                       accept_rd;
  logic                       accept_wr;
  logic                       advance;
  logic                       last_beat;

  // ==================================================
  // Command acceptance
  // ==================================================

  // Only the low address bits select a stored word
  assign address_idx = address[`EMIF_STORE_AW-1:0];

  // Read wins when both strobes arrive together in idle
  assign accept_rd = (state == bank_ctrl_pkg::idle) && read;
  assign accept_wr = (state == bank_ctrl_pkg::idle) && !read && write;

  // One word moves per read cycle, or per write beat once in wr_burst
  assign advance = (state == bank_ctrl_pkg::rd_burst) ||
                   ((state == bank_ctrl_pkg::wr_burst) && write);

  assign last_beat = (remaining == avmm_types_pkg::burst_t'(1));

  // ==================================================
  // State and count
  // ==================================================

  always_ff @(posedge DDR4_USERCLK) begin
    if (rst) begin
      state     <= bank_ctrl_pkg::idle;
      remaining <= '0;
    end else begin
      case (state)
        bank_ctrl_pkg::idle: begin
          if (accept_rd) begin
            state     <= bank_ctrl_pkg::rd_burst;
            remaining <= burstcount;
          end else if (accept_wr) begin
            // The first word is stored with the command itself
            remaining <= burstcount - avmm_types_pkg::burst_t'(1);
            if (burstcount != avmm_types_pkg::burst_t'(1)) begin
              state <= bank_ctrl_pkg::wr_burst;
            end
          end
        end
        bank_ctrl_pkg::rd_burst,
        bank_ctrl_pkg::wr_burst: begin
          if (advance) begin
            remaining <= remaining - avmm_types_pkg::burst_t'(1);
            if (last_beat) begin
              state <= bank_ctrl_pkg::idle;
            end
          end
        end
        default: state <= bank_ctrl_pkg::idle;
      endcase
    end
  end

  // ==================================================
  // Running address and latched enables
  // ==================================================

  always_ff @(posedge DDR4_USERCLK) begin
    if (accept_rd || accept_wr) begin
      // A write has already used its first address by the next cycle
      addr_q <= accept_rd ? address_idx : address_idx + avmm_types_pkg::store_idx_t'(1);
      be_q   <= byteenable;
    end else if (advance) begin
      addr_q <= addr_q + avmm_types_pkg::store_idx_t'(1);
    end
  end

  // Read issue holds off the master for the whole burst
  assign waitrequest = (state == bank_ctrl_pkg::rd_burst);
  assign rd_en       = (state == bank_ctrl_pkg::rd_burst);
  assign wr_en       = accept_wr || ((state == bank_ctrl_pkg::wr_burst) && write);

  // In idle the command word goes straight through to the store
  assign idx     = (state == bank_ctrl_pkg::idle) ? address_idx : addr_q;
  assign lane_be = (state == bank_ctrl_pkg::idle) ? byteenable : be_q;

endmodule

`default_nettype wire

// ==== source/word_store.sv ====
// Word array of one bank with a written bit per word; words never written since rst read as zero
`default_nettype none
`timescale 1ns/1ns

`include "emif_defines.svh"

module word_store (
  input  logic                       DDR4_USERCLK,
  input  logic                       rst,
  input  logic                       wr_en,
  input  logic                       rd_en,
  input  avmm_types_pkg::store_idx_t idx,
  input  avmm_types_pkg::be_t        lane_be,
  input  avmm_types_pkg::data_t      wdata,
  output avmm_types_pkg::data_t      rdata
);

  localparam int STORE_DEPTH = 1 << `EMIF_STORE_AW;

  avmm_types_pkg::data_t mem [STORE_DEPTH];

  // Set once a word has taken any write since reset
  logic [STORE_DEPTH-1:0] written;

  avmm_types_pkg::data_t bit_mask;
  avmm_types_pkg::data_t old_word;
  avmm_types_pkg::data_t merged;

  // ==================================================
  // Byte merge
  // ==================================================

  // Each enable covers one byte lane of the word
  always_comb begin
    for (int i = 0; i < `EMIF_BE_WIDTH; i++) begin
      bit_mask[i*8 +: 8] = {8{lane_be[i]}};
    end
  end

  // An unwritten word merges as if it held zero
  assign old_word = written[idx] ? mem[idx] : '0;
  assign merged   = (old_word & ~bit_mask) | (wdata & bit_mask);

  always_ff @(posedge DDR4_USERCLK) begin
    if (wr_en) begin
      mem[idx] <= merged;
    end
  end

  always_ff @(posedge DDR4_USERCLK) begin
    if (rst) begin
      written <= '0;
    end else if (wr_en) begin
      written[idx] <= 1'b1;
    end
  end

  // ==================================================
  // Registered read
  // ==================================================

  // Data is ready one cycle after rd_en and holds until the next read
  always_ff @(posedge DDR4_USERCLK) begin
    if (rd_en) begin
      rdata <= written[idx] ? mem[idx] : '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_bank.sv ====
// One complete burst slave; readdatavalid has no back-pressure and must be taken when it pulses
`default_nettype none
`timescale 1ns/1ns

module mem_bank (
  input  logic                   DDR4_USERCLK,
  input  logic                   rst,
  input  logic                   read,
  input  logic                   write,
  input  avmm_types_pkg::addr_t  address,
  input  avmm_types_pkg::burst_t burstcount,
  input  avmm_types_pkg::be_t    byteenable,
  input  avmm_types_pkg::data_t  writedata,
  output logic                   waitrequest,
  output avmm_types_pkg::data_t  readdata,
  output logic                   readdatavalid
);

  logic                       rd_en;
  logic                       wr_en;
  avmm_types_pkg::store_idx_t idx;
  avmm_types_pkg::be_t        lane_be;

  // Sequencer turns port commands into one store access per cycle
  burst_ctrl burst_ctrl_inst (
    .DDR4_USERCLK (DDR4_USERCLK),
    .rst          (rst),
    .read         (read),
    .write        (write),
    .address      (address),
    .burstcount   (burstcount),
    .byteenable   (byteenable),
    .waitrequest  (waitrequest),
    .rd_en        (rd_en),
    .wr_en        (wr_en),
    .idx          (idx),
    .lane_be      (lane_be)
  );

  // Write data goes to the store without passing the sequencer
  word_store word_store_inst (
    .DDR4_USERCLK (DDR4_USERCLK),
    .rst          (rst),
    .wr_en        (wr_en),
    .rd_en        (rd_en),
    .idx          (idx),
    .lane_be      (lane_be),
    .wdata        (writedata),
    .rdata        (readdata)
  );

  // The store registers its read, so the strobe lags rd_en by one cycle too
  always_ff @(posedge DDR4_USERCLK) begin
    if (rst) begin
      readdatavalid <= 1'b0;
    end else begin
      readdatavalid <= rd_en;
    end
  end

endmodule

`default_nettype wire

// ==== source/emif_model_top.sv ====
// Two independent DDR4 bank models on DDR4_USERCLK; each stores only the low word address bits
`default_nettype none
`timescale 1ns/1ns

module emif_model_top (
  input  logic                   DDR4_USERCLK,
  input  logic                   rst,

  // ==================================================
  // Bank a
  // ==================================================
  input  logic                   ddr4a_read,
  input  logic                   ddr4a_write,
  input  avmm_types_pkg::addr_t  ddr4a_address,
  input  avmm_types_pkg::burst_t ddr4a_burstcount,
  input  avmm_types_pkg::be_t    ddr4a_byteenable,
  input  avmm_types_pkg::data_t  ddr4a_writedata,
  output logic                   ddr4a_waitrequest,
  output avmm_types_pkg::data_t  ddr4a_readdata,
  output logic                   ddr4a_readdatavalid,

  // ==================================================
  // Bank b
  // ==================================================
  input  logic                   ddr4b_read,
  input  logic                   ddr4b_write,
  input  avmm_types_pkg::addr_t  ddr4b_address,
  input  avmm_types_pkg::burst_t ddr4b_burstcount,
  input  avmm_types_pkg::be_t    ddr4b_byteenable,
  input  avmm_types_pkg::data_t  ddr4b_writedata,
  output logic                   ddr4b_waitrequest,
  output avmm_types_pkg::data_t  ddr4b_readdata,
  output logic                   ddr4b_readdatavalid
);

  // The banks share only clock and reset
  mem_bank bank_a (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .rst           (rst),
    .read          (ddr4a_read),
    .write         (ddr4a_write),
    .address       (ddr4a_address),
    .burstcount    (ddr4a_burstcount),
    .byteenable    (ddr4a_byteenable),
    .writedata     (ddr4a_writedata),
    .waitrequest   (ddr4a_waitrequest),
    .readdata      (ddr4a_readdata),
    .readdatavalid (ddr4a_readdatavalid)
  );

  mem_bank bank_b (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .rst           (rst),
    .read          (ddr4b_read),
    .write         (ddr4b_write),
    .address       (ddr4b_address),
    .burstcount    (ddr4b_burstcount),
    .byteenable    (ddr4b_byteenable),
    .writedata     (ddr4b_writedata),
    .waitrequest   (ddr4b_waitrequest),
    .readdata      (ddr4b_readdata),
    .readdatavalid (ddr4b_readdatavalid)
  );

endmodule

`default_nettype wire

// ==== testbench/emif_model_props.sv ====
// Protocol checks for one bank port; they hold only for legal burstcount values of 1 and up
`default_nettype none
`timescale 1ns/1ns

module emif_model_props (
  input logic DDR4_USERCLK,
  input logic rst,
  input logic read,
  input logic waitrequest,
  input logic readdatavalid
);

  // ==================================================
  // Handshake
  // ==================================================

  // A read burst only starts from idle, where waitrequest is low
  // and read is high on the accepting edge
  wait_rise_needs_read: assert property (
    @(posedge DDR4_USERCLK) disable iff (rst)
      $rose(waitrequest) |-> $past(read && !waitrequest)
  ) else $error("waitrequest rose without an accepted read command");

  // ==================================================
  // Read return
  // ==================================================

  // The last beat of a read trails the fall of waitrequest by one cycle,
  // so three low cycles in a row leave no beat in flight
  no_valid_when_idle: assert property (
    @(posedge DDR4_USERCLK) disable iff (rst)
      (!waitrequest) [*3] |-> !readdatavalid
  ) else $error("readdatavalid high after the bank sat idle");

  // Both strobes come from reset flops and must never go unknown
  strobes_known: assert property (
    @(posedge DDR4_USERCLK) disable iff (rst)
      !$isunknown({waitrequest, readdatavalid})
  ) else $error("waitrequest or readdatavalid is unknown");

endmodule

`default_nettype wire

// ==== testbench/emif_model_tb.sv ====
// Runs testbench/emif_model_input.txt from the project root; bursts of at most 4 words
`default_nettype none
`timescale 1ns/1ns

`include "emif_defines.svh"

module emif_model_tb;

  localparam int RESET_CYCLES = 10;
  localparam int MAX_GAP      = 2;
  localparam int LANES        = `EMIF_DATA_WIDTH / 32;
  localparam int DEPTH        = 1 << `EMIF_STORE_AW;

  logic                   DDR4_USERCLK;
  logic                   rst;
  logic [1:0]             read_s;
  logic [1:0]             write_s;
  avmm_types_pkg::addr_t  addr_s [2];
  avmm_types_pkg::burst_t bc_s [2];
  avmm_types_pkg::be_t    be_s [2];
  avmm_types_pkg::data_t  wdata_s [2];
  logic                   ddr4a_waitrequest;
  logic                   ddr4b_waitrequest;
  logic                   ddr4a_readdatavalid;
  logic                   ddr4b_readdatavalid;
  avmm_types_pkg::data_t  ddr4a_readdata;
  avmm_types_pkg::data_t  ddr4b_readdata;
  wire [1:0]              wait_s;

  // Operation list as loaded from the input file
  string                  op_q [$];
  int                     bank_q [$];
  avmm_types_pkg::addr_t  op_addr_q [$];
  int                     op_bc_q [$];
  avmm_types_pkg::be_t    op_be_q [$];
  logic [31:0]            op_seed_q [$];
  avmm_types_pkg::data_t  file_exp_q [$];

  // Beats still owed by each bank, with the cycle each one is due
  avmm_types_pkg::data_t  exp_data_a [$];
  avmm_types_pkg::data_t  exp_data_b [$];
  int                     exp_cyc_a [$];
  int                     exp_cyc_b [$];
  string                  exp_name_a [$];
  string                  exp_name_b [$];

  // First counter value at which each bank should drop waitrequest again
  int                     wait_end [2];

  // Reference contents of both banks, zero where never written
  avmm_types_pkg::data_t  shadow [2][DEPTH];

  int cycle = 0;
  int cycle_limit = 0;

  assign wait_s = {ddr4b_waitrequest, ddr4a_waitrequest};

  emif_model_top emif_model_top_inst (
    .DDR4_USERCLK        (DDR4_USERCLK),
    .rst                 (rst),
    .ddr4a_read          (read_s[0]),
    .ddr4a_write         (write_s[0]),
    .ddr4a_address       (addr_s[0]),
    .ddr4a_burstcount    (bc_s[0]),
    .ddr4a_byteenable    (be_s[0]),
    .ddr4a_writedata     (wdata_s[0]),
    .ddr4a_waitrequest   (ddr4a_waitrequest),
    .ddr4a_readdata      (ddr4a_readdata),
    .ddr4a_readdatavalid (ddr4a_readdatavalid),
    .ddr4b_read          (read_s[1]),
    .ddr4b_write         (write_s[1]),
    .ddr4b_address       (addr_s[1]),
    .ddr4b_burstcount    (bc_s[1]),
    .ddr4b_byteenable    (be_s[1]),
    .ddr4b_writedata     (wdata_s[1]),
    .ddr4b_waitrequest   (ddr4b_waitrequest),
    .ddr4b_readdata      (ddr4b_readdata),
    .ddr4b_readdatavalid (ddr4b_readdatavalid)
  );

  bind mem_bank emif_model_props bank_props (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .rst           (rst),
    .read          (read),
    .waitrequest   (waitrequest),
    .readdatavalid (readdatavalid)
  );

  always #2 DDR4_USERCLK = ~DDR4_USERCLK;

  // ==================================================
  // Cycle count and timeout
  // ==================================================

  always @(posedge DDR4_USERCLK) begin
    cycle <= cycle + 1;
    if (cycle_limit > 0 && cycle >= cycle_limit) begin
      $display("Run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input avmm_types_pkg::data_t expected,
                             input avmm_types_pkg::data_t actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Every lane of a beat carries the same 32-bit value
  function automatic avmm_types_pkg::data_t lane_word(input logic [31:0] value);
    return {LANES{value}};
  endfunction

  // Byte merge under the enables, applied to the reference copy
  task automatic apply_write(input int bank, input avmm_types_pkg::store_idx_t idx,
                             input avmm_types_pkg::be_t be, input avmm_types_pkg::data_t data);
    for (int i = 0; i < `EMIF_BE_WIDTH; i++) begin
      if (be[i]) shadow[bank][idx][i*8 +: 8] = data[i*8 +: 8];
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge DDR4_USERCLK);
      #1;
    end
  endtask

  // ==================================================
  // Input file
  // ==================================================

  task automatic load_operations();
    int fd;
    int code;
    string tok;
    string bk;
    string line;
    avmm_types_pkg::addr_t addr;
    int bc;
    avmm_types_pkg::be_t be;
    logic [31:0] seed;
    logic [31:0] lane;
    avmm_types_pkg::data_t beat;
    fd = $fopen("testbench/emif_model_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the input file testbench/emif_model_input.txt");
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing input file");
    end else begin
      cycle_limit = RESET_CYCLES + 8;
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok[0] == "#") begin
          code = $fgets(line, fd);
        end else begin
          code = $fscanf(fd, "%s %h %d %h %h", bk, addr, bc, be, seed);
          op_q.push_back(tok);
          bank_q.push_back(bk == "b" ? 1 : 0);
          op_addr_q.push_back(addr);
          op_bc_q.push_back(bc);
          op_be_q.push_back(be);
          op_seed_q.push_back(seed);
          cycle_limit += bc + 8 + MAX_GAP * (bc + 1);
          // Read lines carry one expected beat per word of the burst
          if (tok == "R") begin
            for (int k = 0; k < bc; k++) begin
              for (int j = 0; j < LANES; j++) begin
                code = $fscanf(fd, "%h", lane);
                beat[j*32 +: 32] = lane;
              end
              file_exp_q.push_back(beat);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ==================================================
  // Driver
  // ==================================================

  task automatic push_expect(input int bank, input avmm_types_pkg::data_t data,
                             input int cyc, input string name);
    if (bank == 0) begin
      exp_data_a.push_back(data);
      exp_cyc_a.push_back(cyc);
      exp_name_a.push_back(name);
    end else begin
      exp_data_b.push_back(data);
      exp_cyc_b.push_back(cyc);
      exp_name_b.push_back(name);
    end
  endtask

  // Called at 1 ns after an edge and returns at the same phase
  task automatic run_operation(input int n);
    int b;
    int accept_cyc;
    string name;
    avmm_types_pkg::store_idx_t idx;
    avmm_types_pkg::addr_t addr;
    avmm_types_pkg::data_t exp;
    b = bank_q[n];
    addr = op_addr_q[n];
    idx = addr[`EMIF_STORE_AW-1:0];
    name = $sformatf("op%0d_%s_%s", n, op_q[n], b == 0 ? "a" : "b");
    addr_s[b] = addr;
    bc_s[b] = avmm_types_pkg::burst_t'(op_bc_q[n]);
    be_s[b] = op_be_q[n];
    if (op_q[n] == "R") begin
      read_s[b] = 1'b1;
    end else begin
      write_s[b] = 1'b1;
      wdata_s[b] = lane_word(op_seed_q[n]);
    end
    // Held while a read burst is still being issued
    while (wait_s[b]) wait_cycles(1);
    wait_cycles(1);
    accept_cyc = cycle;
    read_s[b] = 1'b0;
    write_s[b] = 1'b0;
    if (op_q[n] == "R") begin
      wait_end[b] = accept_cyc + op_bc_q[n];
      for (int k = 0; k < op_bc_q[n]; k++) begin
        exp = file_exp_q.pop_front();
        check_value($sformatf("%s_beat%0d_file", name, k), shadow[b][idx], exp);
        // The master takes beat k at edge E+2+k, and at the falling edge
        // before it the counter still reads E+1+k
        push_expect(b, exp, accept_cyc + 1 + k, $sformatf("%s_beat%0d", name, k));
        idx = idx + 1'b1;
      end
    end else begin
      apply_write(b, idx, op_be_q[n], lane_word(op_seed_q[n]));
      for (int k = 1; k < op_bc_q[n]; k++) begin
        wait_cycles($urandom % (MAX_GAP + 1));
        write_s[b] = 1'b1;
        wdata_s[b] = lane_word(op_seed_q[n] + k);
        wait_cycles(1);
        idx = idx + 1'b1;
        apply_write(b, idx, op_be_q[n], wdata_s[b]);
        write_s[b] = 1'b0;
      end
    end
  endtask

  // ==================================================
  // Read beat monitor
  // ==================================================

  task automatic take_beat(input int bank, input avmm_types_pkg::data_t data);
    avmm_types_pkg::data_t exp;
    int exp_cyc;
    string name;
    if ((bank == 0 && exp_data_a.size() == 0) || (bank == 1 && exp_data_b.size() == 0)) begin
      $display("Bank %0d returned a read beat that no read asked for", bank);
      $display("TEST RESULT: FAIL");
      $fatal(1, "unexpected read beat");
    end else begin
      if (bank == 0) begin
        exp = exp_data_a.pop_front();
        exp_cyc = exp_cyc_a.pop_front();
        name = exp_name_a.pop_front();
      end else begin
        exp = exp_data_b.pop_front();
        exp_cyc = exp_cyc_b.pop_front();
        name = exp_name_b.pop_front();
      end
      check_value({name, "_data"}, exp, data);
      check_value({name, "_cycle"}, exp_cyc, cycle);
    end
  endtask

  // Outputs change on the rising edge and are steady at the falling one
  always @(negedge DDR4_USERCLK) begin
    if (!rst) begin
      // A read accepted at counter value c holds waitrequest for its burstcount cycles
      check_value("bank_a_waitrequest", cycle < wait_end[0], wait_s[0]);
      check_value("bank_b_waitrequest", cycle < wait_end[1], wait_s[1]);
      if (ddr4a_readdatavalid) take_beat(0, ddr4a_readdata);
      if (ddr4b_readdatavalid) take_beat(1, ddr4b_readdata);
    end
  end

  initial begin
    DDR4_USERCLK = 1'b0;
    rst = 1'b1;
    read_s = '0;
    write_s = '0;
    for (int b = 0; b < 2; b++) begin
      addr_s[b] = '0;
      bc_s[b] = avmm_types_pkg::burst_t'(1);
      be_s[b] = '0;
      wdata_s[b] = '0;
      wait_end[b] = 0;
      for (int i = 0; i < DEPTH; i++) shadow[b][i] = '0;
    end
    void'($urandom(72051));
    load_operations();
    wait_cycles(RESET_CYCLES);
    rst = 1'b0;
    for (int n = 0; n < op_q.size(); n++) begin
      wait_cycles($urandom % (MAX_GAP + 1));
      run_operation(n);
    end
    while (exp_data_a.size() != 0 || exp_data_b.size() != 0) wait_cycles(1);
    // A few spare cycles let any stray beat show up
    wait_cycles(4);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/emif_model_input.txt ====
# op(R/W) bank(a/b) word_address(hex) burstcount(1..4) byteenable(hex) seed(hex)
# After each R line come the expected beats, 16 hex lanes per beat, lane 0 (bits 31:0) first
R a 0000010 1 ffffffffffffffff 00000000
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
R b 0000010 1 ffffffffffffffff 00000000
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
W a 0000010 4 ffffffffffffffff 00000011
R a 0000010 4 ffffffffffffffff 00000000
11 11 11 11 11 11 11 11 11 11 11 11 11 11 11 11
12 12 12 12 12 12 12 12 12 12 12 12 12 12 12 12
13 13 13 13 13 13 13 13 13 13 13 13 13 13 13 13
14 14 14 14 14 14 14 14 14 14 14 14 14 14 14 14
R b 0000010 2 ffffffffffffffff 00000000
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
W b 0000010 2 ffffffffffffffff 0000003c
R a 0000010 2 ffffffffffffffff 00000000
11 11 11 11 11 11 11 11 11 11 11 11 11 11 11 11
12 12 12 12 12 12 12 12 12 12 12 12 12 12 12 12
R b 0000010 2 ffffffffffffffff 00000000
3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c
3d 3d 3d 3d 3d 3d 3d 3d 3d 3d 3d 3d 3d 3d 3d 3d
W a 0000011 2 2000000000000012 00002200
R a 0000010 4 ffffffffffffffff 00000000
11 11 11 11 11 11 11 11 11 11 11 11 11 11 11 11
2212 0 12 12 12 12 12 12 12 12 12 12 12 12 12 2212
2213 1 13 13 13 13 13 13 13 13 13 13 13 13 13 2213
14 14 14 14 14 14 14 14 14 14 14 14 14 14 14 14
R a 0000012 1 ffffffffffffffff 00000000
2213 1 13 13 13 13 13 13 13 13 13 13 13 13 13 2213
R a 1000011 1 ffffffffffffffff 00000000
2212 0 12 12 12 12 12 12 12 12 12 12 12 12 12 2212

// ==== verilog.f ====
+incdir+source
source/avmm_types_pkg.sv
source/bank_ctrl_pkg.sv
source/burst_ctrl.sv
source/word_store.sv
source/mem_bank.sv
source/emif_model_top.sv
testbench/emif_model_props.sv
testbench/emif_model_tb.sv
